//--- dccm_mem.f
design/dccm_pkg.sv
design/dccm_bank_if.sv
design/dccm_bank_steer.sv
design/dccm_bank.sv
design/dccm_read_mux.sv
design/dccm_mem.sv
testbench/dccm_mem_tb.sv

//--- Makefile
# Verilator build and run for the DCCM memory

VERILATOR ?= verilator
TOP       ?= dccm_mem_tb
RTL_TOP   ?= dccm_mem
FILELIST  ?= dccm_mem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
TIMESCALE ?= 1ns/1ps
JOBS      ?= 0

VFLAGS ?= --timing --assert --timescale $(TIMESCALE)

SRCS := $(wildcard design/*.sv testbench/*.sv)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint lint_rtl sim clean

all: sim

lint: lint_rtl
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

lint_rtl:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/dccm_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dccm_mem_tb;

   localparam int          CLK_PERIOD      = 100;
   localparam int          DRIVE_DELAY     = 10;
   localparam int          RESET_CYCLES    = 3;
   localparam int          NUM_OPS         = 300;
   localparam int          DIRECTED_OPS    = 18;
   localparam int          WATCHDOG_CYCLES = NUM_OPS + DIRECTED_OPS + RESET_CYCLES + 20;
   localparam logic [15:0] LFSR_SEED       = 16'd77;
   // x^16 + x^14 + x^13 + x^11 + 1
   localparam logic [15:0] LFSR_TAPS       = 16'hb400;

   localparam int NUM_WORDS      = dccm_pkg::DCCM_NUM_BANKS * dccm_pkg::DCCM_INDEX_DEPTH;
   // Random window straddles the top word so the address wrap gets hit too
   localparam int RAND_BASE      = NUM_WORDS - 24;
   localparam int RAND_WORD_BITS = 6;

   logic                 clk;
   logic                 rst;
   logic                 dccm_wren;
   logic                 dccm_rden;
   dccm_pkg::dccm_addr_t dccm_wr_addr_lo;
   dccm_pkg::dccm_addr_t dccm_wr_addr_hi;
   dccm_pkg::dccm_addr_t dccm_rd_addr_lo;
   dccm_pkg::dccm_addr_t dccm_rd_addr_hi;
   dccm_pkg::dccm_data_t dccm_wr_data_lo;
   dccm_pkg::dccm_data_t dccm_wr_data_hi;
   dccm_pkg::dccm_data_t dccm_rd_data_lo;
   dccm_pkg::dccm_data_t dccm_rd_data_hi;

   logic [15:0]          lfsr_state;

   // Reference memory keyed by word address
   dccm_pkg::dccm_data_t ref_mem [int];

   // Expected read data, one entry per issued read
   dccm_pkg::dccm_data_t exp_lo_q [$];
   dccm_pkg::dccm_data_t exp_hi_q [$];

   int data_errors  = 0;
   int other_errors = 0;
   int checks_done  = 0;

   dccm_mem dut (
      .clk             (clk),
      .rst             (rst),
      .dccm_wren       (dccm_wren),
      .dccm_rden       (dccm_rden),
      .dccm_wr_addr_lo (dccm_wr_addr_lo),
      .dccm_wr_addr_hi (dccm_wr_addr_hi),
      .dccm_rd_addr_lo (dccm_rd_addr_lo),
      .dccm_rd_addr_hi (dccm_rd_addr_hi),
      .dccm_wr_data_lo (dccm_wr_data_lo),
      .dccm_wr_data_hi (dccm_wr_data_hi),
      .dccm_rd_data_lo (dccm_rd_data_lo),
      .dccm_rd_data_hi (dccm_rd_data_hi)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(CLK_PERIOD / 2);
         clk = ~clk;
      end
   end

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], ^(s & LFSR_TAPS)};
   endfunction

   // One LFSR step per bit taken
   function automatic logic [63:0] take_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         r = {r[62:0], lfsr_state[0]};
      end
      return r;
   endfunction

   function automatic int next_word(input int word);
      return (word + 1) % NUM_WORDS;
   endfunction

   function automatic dccm_pkg::dccm_addr_t word_to_addr(input int word, input int offset);
      return dccm_pkg::dccm_addr_t'(word * dccm_pkg::DCCM_BYTE_WIDTH + offset);
   endfunction

   // Last value written to a word
   function automatic dccm_pkg::dccm_data_t ref_word(input int word);
      if (ref_mem.exists(word)) begin
         return ref_mem[word];
      end
      return 'x;
   endfunction

   task automatic check_data(input string name, input dccm_pkg::dccm_data_t got,
                             input dccm_pkg::dccm_data_t exp);
      checks_done++;
      if (got !== exp) begin
         data_errors++;
         $display("Fail %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      end
   endtask

   task automatic write_access(input int lo_word, input logic misaligned,
                               input dccm_pkg::dccm_data_t data_lo,
                               input dccm_pkg::dccm_data_t data_hi, input int offset);
      int hi_word;
      hi_word = misaligned ? next_word(lo_word) : lo_word;
      @(posedge clk);
      #DRIVE_DELAY;
      dccm_wren       = 1'b1;
      dccm_rden       = 1'b0;
      dccm_wr_addr_lo = word_to_addr(lo_word, offset);
      dccm_wr_addr_hi = misaligned ? word_to_addr(hi_word, 0) : dccm_wr_addr_lo;
      dccm_wr_data_lo = data_lo;
      dccm_wr_data_hi = data_hi;
      ref_mem[lo_word] = data_lo;
      if (misaligned) begin
         ref_mem[hi_word] = data_hi;
      end
   endtask

   task automatic read_access(input int lo_word, input logic misaligned, input int offset);
      int hi_word;
      hi_word = misaligned ? next_word(lo_word) : lo_word;
      @(posedge clk);
      #DRIVE_DELAY;
      dccm_wren       = 1'b0;
      dccm_rden       = 1'b1;
      dccm_rd_addr_lo = word_to_addr(lo_word, offset);
      dccm_rd_addr_hi = misaligned ? word_to_addr(hi_word, 0) : dccm_rd_addr_lo;
      exp_lo_q.push_back(ref_word(lo_word));
      exp_hi_q.push_back(ref_word(hi_word));
   endtask

   task automatic idle_cycle();
      @(posedge clk);
      #DRIVE_DELAY;
      dccm_wren = 1'b0;
      dccm_rden = 1'b0;
   endtask

   // Read data is stable mid-cycle after the strobe edge
   always begin
      @(posedge clk);
      if (!rst && dccm_rden) begin
         @(negedge clk);
         if (exp_lo_q.size() == 0 || exp_hi_q.size() == 0) begin
            other_errors++;
            $display("Read data arrived with no expected value queued at %0t", $time);
         end else begin
            check_data("dccm_rd_data_lo", dccm_rd_data_lo, exp_lo_q.pop_front());
            check_data("dccm_rd_data_hi", dccm_rd_data_hi, exp_hi_q.pop_front());
         end
      end
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Timeout, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Checks %0d, data errors %0d, other errors %0d",
               checks_done, data_errors, other_errors + 1);
      $display("test failed");
      $finish;
   end

   initial begin
      int                   lo_word;
      int                   offset;
      logic                 misaligned;
      logic                 do_write;
      dccm_pkg::dccm_data_t data_lo;
      dccm_pkg::dccm_data_t data_hi;

      lfsr_state      = LFSR_SEED;
      rst             = 1'b1;
      dccm_wren       = 1'b0;
      dccm_rden       = 1'b0;
      dccm_wr_addr_lo = '0;
      dccm_wr_addr_hi = '0;
      dccm_rd_addr_lo = '0;
      dccm_rd_addr_hi = '0;
      dccm_wr_data_lo = '0;
      dccm_wr_data_hi = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      #DRIVE_DELAY;
      rst = 1'b0;

      // Aligned write and read of one word
      write_access(37, 1'b0, 39'h12_3456_789a, '0, 0);
      read_access(37, 1'b0, 0);

      // Misaligned write across banks 2 and 3
      write_access(62, 1'b1, 39'h55_aaaa_0001, 39'h2a_5555_0002, 3);
      read_access(62, 1'b0, 0);
      read_access(63, 1'b0, 0);

      // Bank 3 to bank 0 on the next row
      write_access(243, 1'b1, 39'h0f_0f0f_1234, 39'h70_f0f0_4321, 2);
      read_access(243, 1'b1, 1);
      read_access(243, 1'b0, 0);
      read_access(244, 1'b0, 0);

      // Back-to-back reads, one per cycle
      for (int w = 100; w < 104; w++) begin
         write_access(w, 1'b0, dccm_pkg::dccm_data_t'(39'h3c_0000_0000 + w), '0, 0);
      end
      read_access(103, 1'b0, 0);
      read_access(100, 1'b0, 0);
      read_access(102, 1'b0, 0);
      read_access(101, 1'b1, 1);
      read_access(101, 1'b0, 0);

      for (int n = 0; n < NUM_OPS; n++) begin
         lo_word    = (RAND_BASE + int'(take_bits(RAND_WORD_BITS))) % NUM_WORDS;
         misaligned = (take_bits(1) != 0);
         offset     = int'(take_bits(dccm_pkg::DCCM_WIDTH_BITS));
         do_write   = (take_bits(1) != 0);
         // Only read words the model already holds
         if (!ref_mem.exists(lo_word) ||
             (misaligned && !ref_mem.exists(next_word(lo_word)))) begin
            do_write = 1'b1;
         end
         if (do_write) begin
            data_lo = dccm_pkg::dccm_data_t'(take_bits(dccm_pkg::DCCM_FDATA_WIDTH));
            data_hi = dccm_pkg::dccm_data_t'(take_bits(dccm_pkg::DCCM_FDATA_WIDTH));
            write_access(lo_word, misaligned, data_lo, data_hi, offset);
         end else begin
            read_access(lo_word, misaligned, offset);
         end
      end

      idle_cycle();
      repeat (2) @(posedge clk);

      if (exp_lo_q.size() != 0 || exp_hi_q.size() != 0) begin
         other_errors++;
         $display("%0d reads were issued but never compared", exp_lo_q.size());
      end
      $display("Checks %0d, data errors %0d, other errors %0d",
               checks_done, data_errors, other_errors);
      if (data_errors == 0 && other_errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- design/dccm_mem.sv
`timescale 1ns/1ps
`default_nettype none

module dccm_mem (
   input  logic                 clk,
   input  logic                 rst,

   // Single-cycle strobes
   input  logic                 dccm_wren,
   input  logic                 dccm_rden,

   // Hi equals lo on an aligned access
   input  dccm_pkg::dccm_addr_t dccm_wr_addr_lo,
   input  dccm_pkg::dccm_addr_t dccm_wr_addr_hi,
   input  dccm_pkg::dccm_addr_t dccm_rd_addr_lo,
   input  dccm_pkg::dccm_addr_t dccm_rd_addr_hi,

   input  dccm_pkg::dccm_data_t dccm_wr_data_lo,
   input  dccm_pkg::dccm_data_t dccm_wr_data_hi,

   // Valid the cycle after dccm_rden
   output dccm_pkg::dccm_data_t dccm_rd_data_lo,
   output dccm_pkg::dccm_data_t dccm_rd_data_hi
);

   // One request/data bundle per bank
   dccm_bank_if banks [dccm_pkg::DCCM_NUM_BANKS] ();

   // Lo/hi request decode onto the banks
   dccm_bank_steer u_steer (
      .clk        (clk),
      .wr_en      (dccm_wren),
      .rd_en      (dccm_rden),
      .wr_addr_lo (dccm_wr_addr_lo),
      .wr_addr_hi (dccm_wr_addr_hi),
      .rd_addr_lo (dccm_rd_addr_lo),
      .rd_addr_hi (dccm_rd_addr_hi),
      .wr_data_lo (dccm_wr_data_lo),
      .wr_data_hi (dccm_wr_data_hi),
      .banks      (banks)
   );

   // Word-interleaved banks
   for (genvar i = 0; i < dccm_pkg::DCCM_NUM_BANKS; i++) begin : g_mem_bank
      dccm_bank u_bank (
         .clk  (clk),
         .port (banks[i])
      );
   end : g_mem_bank

   // Bank output selection for lo and hi
   dccm_read_mux u_read_mux (
      .clk        (clk),
      .rst        (rst),
      .rd_en      (dccm_rden),
      .rd_addr_lo (dccm_rd_addr_lo),
      .rd_addr_hi (dccm_rd_addr_hi),
      .banks      (banks),
      .rd_data_lo (dccm_rd_data_lo),
      .rd_data_hi (dccm_rd_data_hi)
   );

endmodule

`default_nettype wire

//--- design/dccm_read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module dccm_read_mux (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  rd_en,
   input  dccm_pkg::dccm_addr_t  rd_addr_lo,
   input  dccm_pkg::dccm_addr_t  rd_addr_hi,
   dccm_bank_if.mux              banks [dccm_pkg::DCCM_NUM_BANKS],
   output dccm_pkg::dccm_data_t  rd_data_lo,
   output dccm_pkg::dccm_data_t  rd_data_hi
);

   dccm_pkg::dccm_data_t     bank_dout [dccm_pkg::DCCM_NUM_BANKS];

   // Bank selects of the read in flight
   dccm_pkg::dccm_bank_sel_t rd_bank_lo_q;
   dccm_pkg::dccm_bank_sel_t rd_bank_hi_q;

   // Gather bank outputs into a plain array for dynamic selection
   for (genvar i = 0; i < dccm_pkg::DCCM_NUM_BANKS; i++) begin : g_dout
      assign bank_dout[i] = banks[i].rdata;
   end : g_dout

   always_ff @(posedge clk) begin
      if (rst) begin
         rd_bank_lo_q <= '0;
         rd_bank_hi_q <= '0;
      end else if (rd_en) begin
         rd_bank_lo_q <= rd_addr_lo[dccm_pkg::DCCM_WIDTH_BITS +: dccm_pkg::DCCM_BANK_BITS];
         rd_bank_hi_q <= rd_addr_hi[dccm_pkg::DCCM_WIDTH_BITS +: dccm_pkg::DCCM_BANK_BITS];
      end
   end

   // Selects line up with the bank data one cycle after the strobe
   assign rd_data_lo = bank_dout[rd_bank_lo_q];
   assign rd_data_hi = bank_dout[rd_bank_hi_q];

endmodule

`default_nettype wire

//--- design/dccm_bank.sv
`timescale 1ns/1ps
`default_nettype none

module dccm_bank (
   input  logic      clk,
   dccm_bank_if.bank port
);

   // Word storage, contents undefined until written
   dccm_pkg::dccm_data_t mem [dccm_pkg::DCCM_INDEX_DEPTH];

   // Synchronous single-port RAM
   always_ff @(posedge clk) begin
      if (port.en) begin
         if (port.we) begin
            mem[port.index] <= port.wdata;
         end else begin
            // Output flop only loads on a read
            port.rdata <= mem[port.index];
         end
      end
   end

   // Steering must never raise a write without the bank strobe
   a_we_needs_en : assert property (
      @(posedge clk) port.we |-> port.en
   ) else $error("bank write without bank enable");

endmodule

`default_nettype wire

//--- design/dccm_bank_steer.sv
`timescale 1ns/1ps
`default_nettype none

module dccm_bank_steer (
   input  logic                 clk,
   input  logic                 wr_en,
   input  logic                 rd_en,
   input  dccm_pkg::dccm_addr_t wr_addr_lo,
   input  dccm_pkg::dccm_addr_t wr_addr_hi,
   input  dccm_pkg::dccm_addr_t rd_addr_lo,
   input  dccm_pkg::dccm_addr_t rd_addr_hi,
   input  dccm_pkg::dccm_data_t wr_data_lo,
   input  dccm_pkg::dccm_data_t wr_data_hi,
   dccm_bank_if.steer           banks [dccm_pkg::DCCM_NUM_BANKS]
);

   dccm_pkg::dccm_bank_sel_t             wr_bank_lo;
   dccm_pkg::dccm_bank_sel_t             wr_bank_hi;
   dccm_pkg::dccm_bank_sel_t             rd_bank_lo;
   dccm_pkg::dccm_bank_sel_t             rd_bank_hi;

   dccm_pkg::dccm_index_t                wr_index_lo;
   dccm_pkg::dccm_index_t                wr_index_hi;
   dccm_pkg::dccm_index_t                rd_index_lo;
   dccm_pkg::dccm_index_t                rd_index_hi;

   logic                                 wr_unaligned;
   logic                                 rd_unaligned;

   logic [dccm_pkg::DCCM_NUM_BANKS-1:0]  wr_sel;
   logic [dccm_pkg::DCCM_NUM_BANKS-1:0]  rd_sel;
   logic [dccm_pkg::DCCM_NUM_BANKS-1:0]  wr_use_hi;
   logic [dccm_pkg::DCCM_NUM_BANKS-1:0]  rd_use_hi;

   // Bank field just above the byte offset
   assign wr_bank_lo = wr_addr_lo[dccm_pkg::DCCM_WIDTH_BITS +: dccm_pkg::DCCM_BANK_BITS];
   assign wr_bank_hi = wr_addr_hi[dccm_pkg::DCCM_WIDTH_BITS +: dccm_pkg::DCCM_BANK_BITS];
   assign rd_bank_lo = rd_addr_lo[dccm_pkg::DCCM_WIDTH_BITS +: dccm_pkg::DCCM_BANK_BITS];
   assign rd_bank_hi = rd_addr_hi[dccm_pkg::DCCM_WIDTH_BITS +: dccm_pkg::DCCM_BANK_BITS];

   // Row index is the top of the address
   assign wr_index_lo = wr_addr_lo[dccm_pkg::DCCM_BITS-1 -: dccm_pkg::DCCM_INDEX_BITS];
   assign wr_index_hi = wr_addr_hi[dccm_pkg::DCCM_BITS-1 -: dccm_pkg::DCCM_INDEX_BITS];
   assign rd_index_lo = rd_addr_lo[dccm_pkg::DCCM_BITS-1 -: dccm_pkg::DCCM_INDEX_BITS];
   assign rd_index_hi = rd_addr_hi[dccm_pkg::DCCM_BITS-1 -: dccm_pkg::DCCM_INDEX_BITS];

   // Two different banks means the access crosses a word boundary
   assign wr_unaligned = (wr_bank_lo != wr_bank_hi);
   assign rd_unaligned = (rd_bank_lo != rd_bank_hi);

   for (genvar i = 0; i < dccm_pkg::DCCM_NUM_BANKS; i++) begin : g_bank

      // Bank hit from either half of the request
      assign wr_sel[i] = wr_en &
                         ((wr_bank_lo == dccm_pkg::dccm_bank_sel_t'(i)) |
                          (wr_bank_hi == dccm_pkg::dccm_bank_sel_t'(i)));
      assign rd_sel[i] = rd_en &
                         ((rd_bank_lo == dccm_pkg::dccm_bank_sel_t'(i)) |
                          (rd_bank_hi == dccm_pkg::dccm_bank_sel_t'(i)));

      // Hi half owns this bank only on a misaligned access
      assign wr_use_hi[i] = wr_unaligned & (wr_bank_hi == dccm_pkg::dccm_bank_sel_t'(i));
      assign rd_use_hi[i] = rd_unaligned & (rd_bank_hi == dccm_pkg::dccm_bank_sel_t'(i));

      assign banks[i].en = rd_sel[i] | wr_sel[i];
      assign banks[i].we = wr_sel[i];

      // Read wins the row when both hit the same bank
      assign banks[i].index = rd_sel[i] ?
                              (rd_use_hi[i] ? rd_index_hi : rd_index_lo) :
                              (wr_use_hi[i] ? wr_index_hi : wr_index_lo);

      assign banks[i].wdata = wr_use_hi[i] ? wr_data_hi : wr_data_lo;

      // Single port per bank, the pipe must never read and write one bank together
      a_no_rw_conflict : assert property (
         @(posedge clk) !(rd_sel[i] && wr_sel[i])
      ) else $error("bank %0d selected for read and write in one cycle", i);

   end : g_bank

endmodule

`default_nettype wire

//--- design/dccm_bank_if.sv
`timescale 1ns/1ps
`default_nettype none

interface dccm_bank_if;

   // Bank access strobe, read or write
   logic                 en;

   // Write when set together with en
   logic                 we;

   // Row selected by the steering logic
   dccm_pkg::dccm_index_t index;

   dccm_pkg::dccm_data_t  wdata;

   // Registered RAM output, holds until the next read
   dccm_pkg::dccm_data_t  rdata;

   // Request side, driven from the lo/hi decode
   modport steer (
      output en,
      output we,
      output index,
      output wdata
   );

   // RAM side
   modport bank (
      input  en,
      input  we,
      input  index,
      input  wdata,
      output rdata
   );

   // Read data selection side
   modport mux (
      input  rdata
   );

endinterface

`default_nettype wire

//--- design/dccm_pkg.sv
`default_nettype none

package dccm_pkg;

   // Memory geometry, 4 KB split over four word-interleaved banks
   localparam int DCCM_BITS        = 12;
   localparam int DCCM_BYTE_WIDTH  = 4;
   localparam int DCCM_WIDTH_BITS  = $clog2(DCCM_BYTE_WIDTH);
   localparam int DCCM_NUM_BANKS   = 4;

   // Bank bits sit right above the byte offset
   localparam int DCCM_BANK_BITS   = $clog2(DCCM_NUM_BANKS);

   // Row index takes the remaining upper address bits
   localparam int DCCM_INDEX_BITS  = DCCM_BITS - DCCM_BANK_BITS - DCCM_WIDTH_BITS;
   localparam int DCCM_INDEX_DEPTH = 1 << DCCM_INDEX_BITS;

   // 32 data bits plus 7 ECC bits per word
   localparam int DCCM_FDATA_WIDTH = 39;

   // Byte address
   typedef logic [DCCM_BITS-1:0]        dccm_addr_t;

   // Bank number
   typedef logic [DCCM_BANK_BITS-1:0]   dccm_bank_sel_t;

   // Row inside one bank
   typedef logic [DCCM_INDEX_BITS-1:0]  dccm_index_t;

   // Stored word
   typedef logic [DCCM_FDATA_WIDTH-1:0] dccm_data_t;

endpackage

`default_nettype wire
